/* Makefile */
SIM = obj_dir/io_system_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ns -f compile.f \
		--top-module io_system_tb -Mdir obj_dir -o io_system_sim

run: compile
	./$(SIM) | tee run.log
	grep -qF "** PASS **" run.log

clean:
	rm -rf obj_dir run.log

/* compile.f */
hdl/constants_pkg.sv
hdl/data_ram.sv
hdl/out_port_bank.sv
hdl/memory_io_mux.sv
hdl/cmd_sequencer.sv
hdl/io_system_top.sv
sim/io_system_tb.sv

/* hdl/cmd_sequencer.sv */
`timescale 1ns/1ns

module cmd_sequencer (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        cmd_valid,
    input  constants_pkg::cmd_word_u                    cmd,
    output logic                                        busy,
    output logic                                        rsp_valid,
    output logic [constants_pkg::MEMORY_DATA_BITS-1:0]  rsp_data,
    output constants_pkg::mem_rd_req_t                  mem_rd,
    output constants_pkg::mem_wr_req_t                  mem_wr,
    input  logic [constants_pkg::MEMORY_DATA_BITS-1:0]  mem_rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        COPY_READ,
        COPY_WRITE
    } state_t;

    state_t                                         state;
    constants_pkg::mem_rd_req_t                     rd_req_q;
    constants_pkg::mem_wr_req_t                     wr_req_q;
    logic [constants_pkg::MEMORY_ADDRESS_BITS-1:0]  dst_addr_q;
    logic                                           accept;

    assign busy = (state != IDLE);
    assign accept = cmd_valid && !busy; // dropped while busy.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            rd_req_q <= '0;
            wr_req_q <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rd_req_q.en <= 1'b0; // requests last one cycle.
            wr_req_q.en <= 1'b0;
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        case (cmd.store.op)
                            constants_pkg::OP_WRITE: begin
                                wr_req_q.en <= 1'b1;
                                wr_req_q.addr <= cmd.store.addr;
                                wr_req_q.data <= cmd.store.data;
                            end
                            constants_pkg::OP_READ: begin
                                rd_req_q.en <= 1'b1;
                                rd_req_q.addr <= cmd.store.addr;
                                state <= READ_WAIT;
                            end
                            constants_pkg::OP_COPY: begin
                                rd_req_q.en <= 1'b1;
                                rd_req_q.addr <= cmd.copy.src_addr;
                                state <= COPY_READ;
                            end
                            default: ;
                        endcase
                    end
                end
                READ_WAIT: begin
                    rsp_valid <= 1'b1; // data arrives with this pulse.
                    state <= IDLE;
                end
                COPY_READ: begin
                    state <= COPY_WRITE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // destination held across the copy.
    always_ff @(posedge clk) begin
        if (accept) begin
            dst_addr_q <= cmd.copy.dst_addr;
        end
    end

    assign mem_rd = rd_req_q;
    assign rsp_data = mem_rd_data;

    // copy write carries the word returned by the bus this cycle.
    always_comb begin
        mem_wr = wr_req_q;
        if (state == COPY_WRITE) begin
            mem_wr.en = 1'b1;
            mem_wr.addr = dst_addr_q;
            mem_wr.data = mem_rd_data;
        end
    end

endmodule

/* hdl/constants_pkg.sv */
package constants_pkg;

    localparam int MEMORY_ADDRESS_BITS = 8;
    localparam int MEMORY_DATA_BITS = 8;
    localparam int NUM_PORTS = 4;
    localparam logic [MEMORY_ADDRESS_BITS-1:0] PORT_BASE_ADDR = 8'hfc;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2,
        OP_COPY  = 2'd3
    } cmd_op_t;

    // write and read form, read ignores data.
    typedef struct packed {
        cmd_op_t                       op;
        logic [MEMORY_ADDRESS_BITS-1:0] addr;
        logic [MEMORY_DATA_BITS-1:0]    data;
    } cmd_store_t;

    typedef struct packed {
        cmd_op_t                       op;
        logic [MEMORY_ADDRESS_BITS-1:0] src_addr;
        logic [MEMORY_ADDRESS_BITS-1:0] dst_addr;
    } cmd_copy_t;

    typedef union packed {
        cmd_store_t store;
        cmd_copy_t  copy;
    } cmd_word_u;

    typedef struct packed {
        logic                           en;
        logic [MEMORY_ADDRESS_BITS-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                           en;
        logic [MEMORY_ADDRESS_BITS-1:0] addr;
        logic [MEMORY_DATA_BITS-1:0]    data;
    } mem_wr_req_t;

    typedef logic [NUM_PORTS-1:0][MEMORY_DATA_BITS-1:0] port_values_t;
    typedef logic [NUM_PORTS-1:0] port_strobes_t;

endpackage

/* hdl/data_ram.sv */
`timescale 1ns/1ns

module data_ram (
    input  logic                                        clk,
    input  constants_pkg::mem_rd_req_t                  ram_rd,
    input  constants_pkg::mem_wr_req_t                  ram_wr,
    output logic [constants_pkg::MEMORY_DATA_BITS-1:0]  ram_rd_data
);

    localparam int DEPTH = 1 << constants_pkg::MEMORY_ADDRESS_BITS;

    logic [constants_pkg::MEMORY_DATA_BITS-1:0] mem [DEPTH];

    // read before write on the same address.
    always_ff @(posedge clk) begin
        if (ram_rd.en) begin
            ram_rd_data <= mem[ram_rd.addr];
        end
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

endmodule

/* hdl/io_system_top.sv */
`timescale 1ns/1ns

module io_system_top (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        cmd_valid,
    input  constants_pkg::cmd_word_u                    cmd,
    output logic                                        busy,
    output logic                                        rsp_valid,
    output logic [constants_pkg::MEMORY_DATA_BITS-1:0]  rsp_data,
    output constants_pkg::port_values_t                 port_data,
    output constants_pkg::port_strobes_t                port_wr
);

    constants_pkg::mem_rd_req_t                 mem_rd;
    constants_pkg::mem_wr_req_t                 mem_wr;
    logic [constants_pkg::MEMORY_DATA_BITS-1:0] mem_rd_data;
    constants_pkg::mem_rd_req_t                 ram_rd;
    constants_pkg::mem_wr_req_t                 ram_wr;
    logic [constants_pkg::MEMORY_DATA_BITS-1:0] ram_rd_data;
    constants_pkg::port_strobes_t               port_wr_en;
    logic [constants_pkg::MEMORY_DATA_BITS-1:0] port_wr_data;

    cmd_sequencer seq_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .mem_rd_data (mem_rd_data)
    );

    memory_io_mux mux_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_rd_data  (mem_rd_data),
        .ram_rd       (ram_rd),
        .ram_wr       (ram_wr),
        .ram_rd_data  (ram_rd_data),
        .port_wr_en   (port_wr_en),
        .port_wr_data (port_wr_data),
        .port_values  (port_data) // readback and top output.
    );

    data_ram ram_i (
        .clk         (clk),
        .ram_rd      (ram_rd),
        .ram_wr      (ram_wr),
        .ram_rd_data (ram_rd_data)
    );

    out_port_bank ports_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .port_wr_en   (port_wr_en),
        .port_wr_data (port_wr_data),
        .port_values  (port_data),
        .port_wr      (port_wr)
    );

endmodule

/* hdl/memory_io_mux.sv */
`timescale 1ns/1ns

module memory_io_mux (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  constants_pkg::mem_rd_req_t                  mem_rd,
    input  constants_pkg::mem_wr_req_t                  mem_wr,
    output logic [constants_pkg::MEMORY_DATA_BITS-1:0]  mem_rd_data,
    output constants_pkg::mem_rd_req_t                  ram_rd,
    output constants_pkg::mem_wr_req_t                  ram_wr,
    input  logic [constants_pkg::MEMORY_DATA_BITS-1:0]  ram_rd_data,
    output constants_pkg::port_strobes_t                port_wr_en,
    output logic [constants_pkg::MEMORY_DATA_BITS-1:0]  port_wr_data,
    input  constants_pkg::port_values_t                 port_values
);

    logic       rd_in_window;
    logic       wr_in_window;
    logic       rd_port_q;
    logic [1:0] rd_idx_q;

    // window is the top four addresses.
    assign rd_in_window = (mem_rd.addr[7:2] == constants_pkg::PORT_BASE_ADDR[7:2]);
    assign wr_in_window = (mem_wr.addr[7:2] == constants_pkg::PORT_BASE_ADDR[7:2]);

    always_comb begin
        ram_rd = mem_rd;
        ram_rd.en = mem_rd.en && !rd_in_window;
        ram_wr = mem_wr;
        ram_wr.en = mem_wr.en && !wr_in_window;
    end

    always_comb begin
        port_wr_en = '0;
        if (mem_wr.en && wr_in_window) begin
            port_wr_en[mem_wr.addr[1:0]] = 1'b1;
        end
    end

    assign port_wr_data = mem_wr.data;

    // remember where the read went for the return cycle.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_port_q <= 1'b0;
            rd_idx_q <= 2'd0;
        end else if (mem_rd.en) begin
            rd_port_q <= rd_in_window;
            rd_idx_q <= mem_rd.addr[1:0];
        end
    end

    assign mem_rd_data = rd_port_q ? port_values[rd_idx_q] : ram_rd_data;

endmodule

/* hdl/out_port_bank.sv */
`timescale 1ns/1ns

module out_port_bank (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  constants_pkg::port_strobes_t                port_wr_en,
    input  logic [constants_pkg::MEMORY_DATA_BITS-1:0]  port_wr_data,
    output constants_pkg::port_values_t                 port_values,
    output constants_pkg::port_strobes_t                port_wr
);

    constants_pkg::port_values_t values_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            values_q <= '0;
        end else begin
            for (int i = 0; i < constants_pkg::NUM_PORTS; i++) begin
                if (port_wr_en[i]) begin
                    values_q[i] <= port_wr_data;
                end
            end
        end
    end

    assign port_values = values_q;
    // strobe comes from the registered request, high in the capture cycle.
    assign port_wr = port_wr_en;

endmodule

/* sim/io_system_tb.sv */
`timescale 1ns/1ns

module io_system_tb;

    localparam int DIRECTED_CMDS = 25;
    localparam int RANDOM_CMDS = 400;
    localparam int CYCLE_LIMIT = (DIRECTED_CMDS + RANDOM_CMDS) * 4 + 100;

    logic                                       clk;
    logic                                       arst_n;
    logic                                       cmd_valid;
    constants_pkg::cmd_word_u                   cmd;
    logic                                       busy;
    logic                                       rsp_valid;
    logic [constants_pkg::MEMORY_DATA_BITS-1:0] rsp_data;
    constants_pkg::port_values_t                port_data;
    constants_pkg::port_strobes_t               port_wr;

    integer      seed;
    int          cycle_count;
    logic [7:0]  model_ram [252];
    bit          ram_written [252];
    logic [7:0]  model_port [4];
    int unsigned written_q [$];

    io_system_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .port_data (port_data),
        .port_wr   (port_wr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("** FAIL **");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        rand_below = {$random(seed)} % n;
    endfunction

    function automatic bit is_port(input logic [7:0] addr);
        is_port = (addr >= constants_pkg::PORT_BASE_ADDR);
    endfunction

    function automatic logic [3:0] strobe_for(input logic [7:0] addr);
        strobe_for = is_port(addr) ? (4'b0001 << addr[1:0]) : 4'b0000;
    endfunction

    function automatic logic [7:0] model_value(input logic [7:0] addr);
        if (is_port(addr)) begin
            model_value = model_port[addr[1:0]];
        end else begin
            model_value = model_ram[addr];
        end
    endfunction

    task automatic model_store(input logic [7:0] addr, input logic [7:0] data);
        if (is_port(addr)) begin
            model_port[addr[1:0]] = data;
        end else begin
            model_ram[addr] = data;
            if (!ram_written[addr]) begin
                ram_written[addr] = 1'b1;
                written_q.push_back(int'(addr));
            end
        end
    endtask

    // a port, or a ram address that holds known data.
    function automatic logic [7:0] pick_readable();
        if (rand_below(4) == 0) begin
            pick_readable = constants_pkg::PORT_BASE_ADDR + 8'(rand_below(4));
        end else begin
            pick_readable = 8'(written_q[rand_below(written_q.size())]);
        end
    endfunction

    task automatic check_ports();
        constants_pkg::port_values_t expected;
        for (int i = 0; i < 4; i++) begin
            expected[i] = model_port[i];
        end
        check_value(32'(expected), 32'(port_data), "port_data");
    endtask

    // runs one command; a and b are addr/data or src/dst.
    task automatic issue_cmd(input constants_pkg::cmd_op_t op, input logic [7:0] a,
                             input logic [7:0] b);
        constants_pkg::cmd_word_u c;
        logic [7:0]               value;
        int                       waited;
        c = '0;
        if (op == constants_pkg::OP_COPY) begin
            c.copy.op = op;
            c.copy.src_addr = a;
            c.copy.dst_addr = b;
        end else begin
            c.store.op = op;
            c.store.addr = a;
            c.store.data = b;
        end
        while (busy) begin
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b1;
        cmd = c;
        @(posedge clk); // acceptance edge.
        #2;
        cmd_valid = 1'b0;
        cmd = '0;
        case (op)
            constants_pkg::OP_WRITE: begin
                check_value(0, 32'(busy), "busy during write");
                check_value(0, 32'(rsp_valid), "rsp_valid during write");
                check_value(32'(strobe_for(a)), 32'(port_wr), "write strobe");
                model_store(a, b);
                @(posedge clk);
                #2;
            end
            constants_pkg::OP_READ: begin
                check_value(1, 32'(busy), "busy during read");
                check_value(0, 32'(port_wr), "strobe during read");
                value = model_value(a);
                waited = 0;
                while (!rsp_valid) begin
                    @(posedge clk);
                    #2;
                    waited++;
                end
                check_value(1, 32'(waited), "read latency");
                check_value(32'(value), 32'(rsp_data), "read data");
                check_value(0, 32'(port_wr), "strobe at read response");
                @(posedge clk);
                #2;
            end
            constants_pkg::OP_COPY: begin
                check_value(1, 32'(busy), "busy in copy read");
                check_value(0, 32'(rsp_valid), "rsp_valid in copy read");
                check_value(0, 32'(port_wr), "strobe in copy read");
                value = model_value(a);
                @(posedge clk);
                #2;
                check_value(1, 32'(busy), "busy in copy write");
                check_value(0, 32'(rsp_valid), "rsp_valid in copy write");
                check_value(32'(strobe_for(b)), 32'(port_wr), "copy strobe");
                model_store(b, value);
                @(posedge clk);
                #2;
            end
            default: begin
                check_value(0, 32'(busy), "busy during nop");
                check_value(0, 32'(rsp_valid), "rsp_valid during nop");
                check_value(0, 32'(port_wr), "strobe during nop");
                @(posedge clk);
                #2;
            end
        endcase
        check_value(0, 32'(busy), "busy after command");
        check_value(0, 32'(rsp_valid), "rsp_valid after command");
        check_value(0, 32'(port_wr), "strobe after command");
        check_ports();
    endtask

    initial begin
        logic [7:0] addr;
        logic [7:0] dst;
        seed = 79;
        cycle_count = 0;
        arst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        for (int i = 0; i < 4; i++) begin
            model_port[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_value(0, 32'(busy), "busy after reset");
        check_value(0, 32'(rsp_valid), "rsp_valid after reset");
        check_value(0, 32'(port_wr), "port_wr after reset");
        check_ports();

        // one address per quarter of ram, so all four differ.
        for (int i = 0; i < 4; i++) begin
            addr = 8'(i * 63 + rand_below(63));
            issue_cmd(constants_pkg::OP_WRITE, addr, 8'(rand_below(256)));
            issue_cmd(constants_pkg::OP_READ, addr, 8'h00);
        end

        for (int i = 0; i < 4; i++) begin
            issue_cmd(constants_pkg::OP_WRITE, constants_pkg::PORT_BASE_ADDR + 8'(i),
                      8'(rand_below(256)));
        end

        // ports read back, ram left alone by port writes.
        for (int i = 0; i < 4; i++) begin
            issue_cmd(constants_pkg::OP_READ, constants_pkg::PORT_BASE_ADDR + 8'(i), 8'h00);
        end
        for (int i = 0; i < 4; i++) begin
            issue_cmd(constants_pkg::OP_READ, 8'(written_q[i]), 8'h00);
        end

        dst = 8'(rand_below(252));
        issue_cmd(constants_pkg::OP_COPY, 8'(written_q[0]), dst);
        issue_cmd(constants_pkg::OP_READ, dst, 8'h00);
        issue_cmd(constants_pkg::OP_COPY, 8'(written_q[1]), constants_pkg::PORT_BASE_ADDR + 8'd2);
        dst = 8'(rand_below(252));
        issue_cmd(constants_pkg::OP_COPY, constants_pkg::PORT_BASE_ADDR + 8'd1, dst);
        issue_cmd(constants_pkg::OP_READ, dst, 8'h00);

        for (int k = 0; k < RANDOM_CMDS; k++) begin
            case (rand_below(4))
                0: issue_cmd(constants_pkg::OP_NOP, 8'h00, 8'h00);
                1: issue_cmd(constants_pkg::OP_WRITE, 8'(rand_below(256)), 8'(rand_below(256)));
                2: issue_cmd(constants_pkg::OP_READ, pick_readable(), 8'h00);
                default: issue_cmd(constants_pkg::OP_COPY, pick_readable(), 8'(rand_below(256)));
            endcase
        end

        $display("** PASS **");
        $finish;
    end

endmodule
